// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and instruction word width
`define CPU_DATA_W 16

// Register file depth
`define CPU_REG_COUNT 16

// Program counter value after reset
`define CPU_RESET_PC 16'h0000

// All-zero word decodes as NOP
`define CPU_NOP_WORD 16'h0000

`endif

// File: source/cpu_pkg.sv
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] wordT;
  typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regAddrT;

  // Instruction bits 15..12
  typedef enum logic [3:0] {
    NOP = 4'd0,
    ADD = 4'd1,
    SUB = 4'd2,
    AND = 4'd3,
    XOR = 4'd4,
    LLB = 4'd5,
    B   = 4'd6,
    BZ  = 4'd7,
    HLT = 4'd15
  } opcodeT;

  // Fetch to decode payload
  typedef struct packed {
    wordT instr;
    wordT pc;
  } fetchPacketT;

  // Decode to execute payload where all zeros is a NOP
  typedef struct packed {
    opcodeT  opcode;
    regAddrT rd;
    regAddrT rs;
    regAddrT rt;
    wordT    rsVal;
    wordT    rtVal;
    wordT    imm;
    wordT    pc;
    logic    writesReg;
    logic    setsZero;
  } decodedOpT;

endpackage

// File: source/reg_read_if.sv
`timescale 1ns/1ns

// Two register read ports between decode and the register file
interface regReadIf import cpu_pkg::*; ();

  regAddrT rsAddr;
  regAddrT rtAddr;
  wordT    rsData;
  wordT    rtData;

  // Decode side drives addresses
  modport reader (
    output rsAddr,
    output rtAddr,
    input  rsData,
    input  rtData
  );

  modport server (
    input  rsAddr,
    input  rtAddr,
    output rsData,
    output rtData
  );

endinterface

// File: source/fetch_unit.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module fetchUnit import cpu_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic hold,
  input  logic redirect,
  input  wordT target,
  output wordT pc
);

  wordT pcNext;

  // Next address selection
  always_comb begin
    if (redirect) begin
      pcNext = target;
    end else begin
      pcNext = pc + 1'b1;
    end
  end

  // Program counter register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= `CPU_RESET_PC;
    end else if (!hold) begin
      pc <= pcNext;
    end
  end

endmodule

// File: source/pipe_reg.sv
`timescale 1ns/1ns

// Stage register shared by the fetch and decode payloads
module pipeReg import cpu_pkg::*; #(
  parameter type payloadT = fetchPacketT
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    hold,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (!hold) begin
      // Hold wins and a flush waits for the stall to end
      if (flush) begin
        q <= '0;
      end else begin
        q <= d;
      end
    end
  end

endmodule

// File: source/decode_unit.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module decodeUnit import cpu_pkg::*; (
  input  fetchPacketT     fetched,
  regReadIf.reader        regs,
  output decodedOpT       decoded
);

  opcodeT  opcode;
  regAddrT rd;
  regAddrT rs;
  regAddrT rt;
  logic    isAlu;

  // Field split
  assign rd = fetched.instr[11:8];
  assign rs = fetched.instr[7:4];
  assign rt = fetched.instr[3:0];

  assign regs.rsAddr = rs;
  assign regs.rtAddr = rt;

  // Unused opcodes collapse to NOP here
  always_comb begin
    case (fetched.instr[15:12])
      ADD, SUB, AND, XOR, LLB, B, BZ, HLT: begin
        opcode = opcodeT'(fetched.instr[15:12]);
      end
      default: begin
        opcode = NOP;
      end
    endcase
  end

  assign isAlu = (opcode == ADD) || (opcode == SUB) ||
                 (opcode == AND) || (opcode == XOR);

  always_comb begin
    decoded.opcode = opcode;
    decoded.rd     = rd;
    decoded.rs     = rs;
    decoded.rt     = rt;
    decoded.rsVal  = regs.rsData;
    decoded.rtVal  = regs.rtData;
    // Sign-extended 8-bit immediate
    decoded.imm    = {{(`CPU_DATA_W-8){fetched.instr[7]}}, fetched.instr[7:0]};
    decoded.pc     = fetched.pc;
    // Writes to r0 are dropped at decode
    decoded.writesReg = (isAlu || opcode == LLB) && (rd != '0);
    decoded.setsZero  = isAlu;
  end

endmodule

// File: source/reg_file.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module regFile import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  regReadIf.server regs,
  input  logic     wrEn,
  input  regAddrT  wrAddr,
  input  wordT     wrData
);

  wordT regArray [`CPU_REG_COUNT];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regArray[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      regArray[wrAddr] <= wrData;
    end
  end

  // Read ports with write-through bypass and r0 hardwired to zero
  assign regs.rsData = (regs.rsAddr == '0) ? '0 :
                       (wrEn && wrAddr == regs.rsAddr) ? wrData :
                       regArray[regs.rsAddr];

  assign regs.rtData = (regs.rtAddr == '0) ? '0 :
                       (wrEn && wrAddr == regs.rtAddr) ? wrData :
                       regArray[regs.rtAddr];

endmodule

// File: source/execute_unit.sv
`timescale 1ns/1ns

module executeUnit import cpu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      hold,
  input  decodedOpT op,
  output logic      redirect,
  output wordT      target,
  output logic      flush,
  output logic      wrEn,
  output regAddrT   wrAddr,
  output wordT      wrData,
  output logic      halted
);

  // Most recent register write
  logic    lastValid;
  regAddrT lastAddr;
  wordT    lastData;

  logic    zeroFlag;
  logic    taken;
  wordT    rsVal;
  wordT    rtVal;
  wordT    result;

  //**************************************************************************
  // Operand forwarding and ALU
  //**************************************************************************
  assign rsVal = (lastValid && lastAddr == op.rs) ? lastData : op.rsVal;
  assign rtVal = (lastValid && lastAddr == op.rt) ? lastData : op.rtVal;

  always_comb begin
    case (op.opcode)
      ADD:     result = rsVal + rtVal;
      SUB:     result = rsVal - rtVal;
      AND:     result = rsVal & rtVal;
      XOR:     result = rsVal ^ rtVal;
      LLB:     result = op.imm;
      default: result = '0;
    endcase
  end

  //**************************************************************************
  // Branch, halt and write port
  //**************************************************************************
  assign taken = (op.opcode == B) || (op.opcode == BZ && zeroFlag);

  // HLT redirects to itself so nothing younger survives
  assign redirect = !halted && (taken || op.opcode == HLT);
  assign target   = (op.opcode == HLT) ? op.pc : op.pc + 1'b1 + op.imm;
  assign flush    = redirect || halted;

  assign wrEn   = op.writesReg && !halted && !hold;
  assign wrAddr = op.rd;
  assign wrData = result;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      zeroFlag  <= 1'b0;
      halted    <= 1'b0;
      lastValid <= 1'b0;
    end else if (!hold && !halted) begin
      if (op.setsZero) begin
        zeroFlag <= (result == '0);
      end
      if (op.opcode == HLT) begin
        halted <= 1'b1;
      end
      if (wrEn) begin
        lastValid <= 1'b1;
      end
    end
  end

  // Forwarding payload
  always_ff @(posedge clk) begin
    if (wrEn) begin
      lastAddr <= wrAddr;
      lastData <= wrData;
    end
  end

endmodule

// File: source/cpu.sv
`timescale 1ns/1ns

module cpu import cpu_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    hold,
  input  wordT    instr,
  output wordT    pc,
  output logic    halt,
  output logic    wrEn,
  output regAddrT wrAddr,
  output wordT    wrData
);

  logic        fetchHold;
  logic        redirect;
  logic        flush;
  wordT        target;
  fetchPacketT fetchIn;
  fetchPacketT fetchOut;
  decodedOpT   decodedIn;
  decodedOpT   decodedOut;

  regReadIf regPort ();

  //**************************************************************************
  // Fetch
  //**************************************************************************
  // PC freezes once the core has halted
  assign fetchHold = hold | halt;

  fetchUnit fetchInst (
    .clk      (clk),
    .rst_n    (rst_n),
    .hold     (fetchHold),
    .redirect (redirect),
    .target   (target),
    .pc       (pc)
  );

  assign fetchIn = '{instr: instr, pc: pc};

  pipeReg #(.payloadT(fetchPacketT)) fetchStage (
    .clk   (clk),
    .rst_n (rst_n),
    .hold  (hold),
    .flush (flush),
    .d     (fetchIn),
    .q     (fetchOut)
  );

  //**************************************************************************
  // Decode
  //**************************************************************************
  decodeUnit decodeInst (
    .fetched (fetchOut),
    .regs    (regPort.reader),
    .decoded (decodedIn)
  );

  regFile regFileInst (
    .clk    (clk),
    .rst_n  (rst_n),
    .regs   (regPort.server),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData)
  );

  pipeReg #(.payloadT(decodedOpT)) decodeStage (
    .clk   (clk),
    .rst_n (rst_n),
    .hold  (hold),
    .flush (flush),
    .d     (decodedIn),
    .q     (decodedOut)
  );

  //**************************************************************************
  // Execute
  //**************************************************************************
  executeUnit executeInst (
    .clk      (clk),
    .rst_n    (rst_n),
    .hold     (hold),
    .op       (decodedOut),
    .redirect (redirect),
    .target   (target),
    .flush    (flush),
    .wrEn     (wrEn),
    .wrAddr   (wrAddr),
    .wrData   (wrData),
    .halted   (halt)
  );

endmodule

// File: testbench/cpu_checker.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

// Watches the write port and the halt output of the core
module cpu_checker (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   wrEn,
  input logic [3:0]             wrAddr,
  input logic [`CPU_DATA_W-1:0] wrData,
  input logic                   halt,
  input logic [`CPU_DATA_W-1:0] pc
);

  // Expected writes as {address, data}
  logic [19:0]            expected [8];
  int                     expCount = 0;
  int                     seenCount = 0;
  int                     errorCount = 0;
  logic                   armed = 1'b0;
  logic                   haltSeen = 1'b0;
  logic [`CPU_DATA_W-1:0] haltPc;

  task automatic setExpected(input int index, input logic [19:0] pair);
    expected[index] = pair;
  endtask

  task automatic armTest(input int count);
    expCount = count;
    seenCount = 0;
    errorCount = 0;
    haltSeen = 1'b0;
    armed = 1'b1;
  endtask

  task automatic finishTest(output int errors);
    if (seenCount < expCount) begin
      $display("Missing writes: expected %0d, only %0d seen", expCount, seenCount);
      errorCount++;
    end
    armed = 1'b0;
    errors = errorCount;
  endtask

  // Sampled at the rising edge before the core updates
  always @(posedge clk) begin
    if (armed && rst_n) begin
      if (wrEn && seenCount < expCount) begin
        if (wrAddr !== expected[seenCount][19:16]) begin
          $display("Error: time %0t, wrAddr expected %0d, actual %0d",
                   $time, expected[seenCount][19:16], wrAddr);
          errorCount++;
        end
        if (wrData !== expected[seenCount][15:0]) begin
          $display("Error: time %0t, wrData expected %h, actual %h",
                   $time, expected[seenCount][15:0], wrData);
          errorCount++;
        end
      end else if (wrEn) begin
        $display("Unexpected extra write of %h to r%0d at time %0t", wrData, wrAddr, $time);
        errorCount++;
      end
      if (wrEn) begin
        seenCount++;
      end
      // Halt is sticky and the pc must freeze
      if (haltSeen && !halt) begin
        $display("Error: time %0t, halt expected 1, actual %b", $time, halt);
        errorCount++;
      end else if (haltSeen && pc !== haltPc) begin
        $display("Error: time %0t, pc expected %h, actual %h", $time, haltPc, pc);
        errorCount++;
      end else if (halt) begin
        haltSeen = 1'b1;
        haltPc = pc;
      end
    end
  end

endmodule

// File: testbench/cpu_tb.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module cpu_tb;

  localparam int NUM_TESTS    = 6;
  localparam int ROM_WORDS    = 32;
  localparam int HALT_TIMEOUT = 200;

  logic                   clk;
  logic                   rst_n;
  logic                   hold;
  logic [`CPU_DATA_W-1:0] instr;
  logic [`CPU_DATA_W-1:0] pc;
  logic                   halt;
  logic                   wrEn;
  logic [3:0]             wrAddr;
  logic [`CPU_DATA_W-1:0] wrData;

  logic [`CPU_DATA_W-1:0] rom [ROM_WORDS];
  logic                   holdRandom;
  int unsigned            lcgState;
  int                     passCount;
  int                     failCount;

  // Test table with expected writes packed as {address, data}
  string                  testName  [NUM_TESTS];
  logic [`CPU_DATA_W-1:0] progWords [NUM_TESTS][16];
  logic                   holdMode  [NUM_TESTS];
  logic [19:0]            expWrites [NUM_TESTS][8];
  int                     expCount  [NUM_TESTS];

  cpu cpu_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .hold   (hold),
    .instr  (instr),
    .pc     (pc),
    .halt   (halt),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData)
  );

  cpu_checker checkInst (
    .clk    (clk),
    .rst_n  (rst_n),
    .wrEn   (wrEn),
    .wrAddr (wrAddr),
    .wrData (wrData),
    .halt   (halt),
    .pc     (pc)
  );

  always #2 clk = ~clk;

  function automatic int unsigned lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // Instruction ROM and hold change on the falling edge
  always @(negedge clk) begin
    if (pc < ROM_WORDS) begin
      instr = rom[pc[4:0]];
    end else begin
      instr = `CPU_NOP_WORD;
    end
    // High about one cycle in three
    hold = holdRandom && (((lcgNext() >> 16) % 3) == 0);
  end

  //**************************************************************************
  // Programs and expected writes
  //**************************************************************************
  task automatic buildTable();
    // 35 + FF9A, 35 - FF9A, 35 & FF9A, 35 ^ FF9A, then LLB r0 and ADD r7 from r0
    testName[0]  = "alu and r0";
    progWords[0] = '{16'h5135, 16'h529A, 16'h1312, 16'h2412, 16'h3512, 16'h4612, 16'h507F,
                     16'h1701, 16'hF000, 16'h5801, 16'h5802, 16'h0000, 16'h0000, 16'h0000,
                     16'h0000, 16'h0000};
    expWrites[0] = '{20'h10035, 20'h2FF9A, 20'h3FFCF, 20'h4009B, 20'h50010, 20'h6FFAF,
                     20'h70035, 20'h00000};
    expCount[0]  = 7;
    // 3 + 5 = 8, 8 + 3 = B, B + 8 = 13, 13 + 13 = 26, 26 + B = 31
    testName[1]  = "forwarding";
    progWords[1] = '{16'h5103, 16'h5205, 16'h1312, 16'h1431, 16'h1543, 16'h1655, 16'h1164,
                     16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
                     16'h0000, 16'h0000};
    expWrites[1] = '{20'h10003, 20'h20005, 20'h30008, 20'h4000B, 20'h50013, 20'h60026,
                     20'h10031, 20'h00000};
    expCount[1]  = 7;
    // BZ at 3 goes to 6, BZ at 7 falls through, B at 9 goes to 13, B at 14 back to 12
    testName[2]  = "branches";
    progWords[2] = '{16'h5105, 16'h5205, 16'h2312, 16'h7002, 16'h5411, 16'h5522, 16'h2610,
                     16'h7004, 16'h5777, 16'h6003, 16'h5812, 16'h5913, 16'hF000, 16'h5A0A,
                     16'h60FD, 16'h5B0B};
    expWrites[2] = '{20'h10005, 20'h20005, 20'h30000, 20'h60005, 20'h70077, 20'hA000A,
                     20'h00000, 20'h00000};
    expCount[2]  = 6;
    testName[3]  = "forwarding with hold";
    progWords[3] = progWords[1];
    expWrites[3] = expWrites[1];
    expCount[3]  = expCount[1];
    testName[4]  = "branches with hold";
    progWords[4] = progWords[2];
    expWrites[4] = expWrites[2];
    expCount[4]  = expCount[2];
    // Nothing after HLT may write
    testName[5]  = "halt";
    progWords[5] = '{16'h5142, 16'hF000, 16'h5255, 16'h5366, 16'h1411, 16'h0000, 16'h0000,
                     16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
                     16'h0000, 16'h0000};
    expWrites[5] = '{20'h10042, 20'h00000, 20'h00000, 20'h00000, 20'h00000, 20'h00000,
                     20'h00000, 20'h00000};
    expCount[5]  = 1;
    holdMode     = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
  endtask

  task automatic loadRom(input int t);
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = (i < 16) ? progWords[t][i] : `CPU_NOP_WORD;
    end
  endtask

  task automatic waitForHalt(output logic reached);
    int cycles;
    cycles = 0;
    while (!halt && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    reached = halt;
  endtask

  task automatic runTest(input int t);
    int   errors;
    logic reached;
    @(negedge clk);
    loadRom(t);
    holdRandom = holdMode[t];
    for (int i = 0; i < 8; i++) begin
      checkInst.setExpected(i, expWrites[t][i]);
    end
    checkInst.armTest(expCount[t]);
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    waitForHalt(reached);
    if (!reached) begin
      $display("Timeout: test %0d did not halt within %0d cycles", t, HALT_TIMEOUT);
    end
    // Extra cycles catch stray writes past HLT
    repeat (10) @(negedge clk);
    checkInst.finishTest(errors);
    errors += reached ? 0 : 1;
    if (errors == 0) begin
      passCount++;
      $display("Test %0d %s: ok", t, testName[t]);
    end else begin
      failCount++;
      $display("Test %0d %s: failed with %0d errors", t, testName[t], errors);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    hold = 1'b0;
    instr = `CPU_NOP_WORD;
    holdRandom = 1'b0;
    lcgState = 50;
    passCount = 0;
    failCount = 0;
    buildTable();
    for (int t = 0; t < NUM_TESTS; t++) begin
      runTest(t);
    end
    $display("Tests: %0d, passing: %0d, failing: %0d", NUM_TESTS, passCount, failCount);
    if (failCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
source/cpu_pkg.sv
source/reg_read_if.sv
source/fetch_unit.sv
source/pipe_reg.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/cpu.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// File: Makefile
SIM_LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module cpu_tb

# Warnings still print but do not stop the build
sim:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module cpu_tb -o cpu_tb_sim
	./obj_dir/cpu_tb_sim | tee $(SIM_LOG)
	grep -q "SIMULATION PASSED" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
